//--- files.f
+incdir+.
mips_isa_pkg.sv
mips_ctrl_pkg.sv
mips_fetch.sv
mips_regfile.sv
mips_decode.sv
mips_execute.sv
mips_memory.sv
mips_top.sv
tb_mips.sv

//--- run.sh
#!/bin/sh
# Compile and run the MIPS pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -sv -f files.f --top-module tb_mips -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mips > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

//--- tb_mips.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_settings.svh"

module tb_mips;

    // --------------------
    // Test sizes
    // --------------------
    localparam int CLK_PERIOD = 10;
    localparam int NUM_TESTS  = 10;
    localparam int PROG_LEN   = 40;                 // Random instructions per test
    localparam int NUM_POOL   = 6;                  // Registers r0 to r5, many hazards
    localparam int MEM_WINDOW = 8;                  // Data words touched per test
    localparam int DMEM_WORDS = 2 ** `MIPS_NB_DMEM_ADDR;
    // Zeroing prologue, random body and halt
    localparam int PROG_WORDS = (NUM_POOL - 1) + MEM_WINDOW + PROG_LEN + 1;
    localparam int WATCHDOG_NS = NUM_TESTS * PROG_WORDS * 200 * CLK_PERIOD;

    logic                              clock;
    logic                              rst;
    logic                              run;
    logic                              load_we;
    logic [7:0]                        load_byte;
    mips_isa_pkg::reg_addr_t           dbg_reg_addr;
    logic [`MIPS_NB_DMEM_ADDR - 1 : 0] dbg_mem_addr;
    mips_isa_pkg::word_t               dbg_reg;
    mips_isa_pkg::word_t               dbg_mem;
    mips_isa_pkg::word_t               dbg_pc;
    logic                              program_end;

    integer              seed;
    int                  fail_count;
    int                  prog_len;
    int                  win_base;                  // First data word of the window
    mips_isa_pkg::word_t prog       [0:PROG_WORDS - 1];
    mips_isa_pkg::word_t model_regs [0:31];
    mips_isa_pkg::word_t model_mem  [0:DMEM_WORDS - 1];

    mips_top DUT (
        .o_dbg_reg        (dbg_reg     ),
        .o_dbg_mem        (dbg_mem     ),
        .o_dbg_pc         (dbg_pc      ),
        .o_is_program_end (program_end ),
        .i_dbg_reg_addr   (dbg_reg_addr),
        .i_dbg_mem_addr   (dbg_mem_addr),
        .i_load_byte      (load_byte   ),
        .i_load_we        (load_we     ),
        .i_run            (run         ),
        .i_rst            (rst         ),
        .i_clock          (clock       )
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // --------------------
    // Program generation
    // --------------------
    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic mips_isa_pkg::word_t encode_rtype(
        input mips_isa_pkg::funct_t    fn,
        input mips_isa_pkg::reg_addr_t rs,
        input mips_isa_pkg::reg_addr_t rt,
        input mips_isa_pkg::reg_addr_t rd
    );
        return {6'h00, rs, rt, rd, 5'h00, fn};      // Shift amount unused
    endfunction

    function automatic mips_isa_pkg::word_t encode_itype(
        input mips_isa_pkg::opcode_t   op,
        input mips_isa_pkg::reg_addr_t rs,
        input mips_isa_pkg::reg_addr_t rt,
        input logic [15:0]             imm
    );
        return {op, rs, rt, imm};
    endfunction

    // Byte offset of a random word in the window, base register is r0
    function automatic logic [15:0] window_offset();
        return 16'((win_base + rand_below(MEM_WINDOW)) * 4);
    endfunction

    task automatic build_program();
        int                      n;
        int                      i;
        int                      k;
        mips_isa_pkg::reg_addr_t rs;
        mips_isa_pkg::reg_addr_t rt;
        mips_isa_pkg::reg_addr_t rd;
        logic [15:0]             imm;
        n        = 0;
        win_base = rand_below(DMEM_WORDS - MEM_WINDOW + 1);
        // Prologue clears pool registers and window words
        for (i = 1; i < NUM_POOL; i++) begin
            prog[n] = encode_rtype(mips_isa_pkg::FN_ADD, '0, '0, mips_isa_pkg::reg_addr_t'(i));
            n++;
        end
        for (i = 0; i < MEM_WINDOW; i++) begin
            prog[n] = encode_itype(mips_isa_pkg::OP_SW, '0, '0, 16'((win_base + i) * 4));
            n++;
        end
        for (i = 0; i < PROG_LEN; i++) begin
            k   = rand_below(18);                   // Loads weighted up for stalls
            rs  = mips_isa_pkg::reg_addr_t'(rand_below(NUM_POOL));
            rt  = mips_isa_pkg::reg_addr_t'(rand_below(NUM_POOL));   // r0 as target too
            rd  = mips_isa_pkg::reg_addr_t'(rand_below(NUM_POOL));
            imm = 16'(rand_below(65536));
            case (k)
                0:  prog[n] = encode_rtype(mips_isa_pkg::FN_ADD, rs, rt, rd);
                1:  prog[n] = encode_rtype(mips_isa_pkg::FN_SUB, rs, rt, rd);
                2:  prog[n] = encode_rtype(mips_isa_pkg::FN_AND, rs, rt, rd);
                3:  prog[n] = encode_rtype(mips_isa_pkg::FN_OR,  rs, rt, rd);
                4:  prog[n] = encode_rtype(mips_isa_pkg::FN_XOR, rs, rt, rd);
                5:  prog[n] = encode_rtype(mips_isa_pkg::FN_NOR, rs, rt, rd);
                6:  prog[n] = encode_rtype(mips_isa_pkg::FN_SLT, rs, rt, rd);
                7:  prog[n] = encode_itype(mips_isa_pkg::OP_ADDI, rs, rt, imm);
                8:  prog[n] = encode_itype(mips_isa_pkg::OP_SLTI, rs, rt, imm);
                9:  prog[n] = encode_itype(mips_isa_pkg::OP_ANDI, rs, rt, imm);
                10: prog[n] = encode_itype(mips_isa_pkg::OP_ORI,  rs, rt, imm);
                11: prog[n] = encode_itype(mips_isa_pkg::OP_XORI, rs, rt, imm);
                12: prog[n] = encode_itype(mips_isa_pkg::OP_LUI,  '0, rt, imm);
                13, 14, 15: prog[n] = encode_itype(mips_isa_pkg::OP_LW, '0, rt, window_offset());
                default:    prog[n] = encode_itype(mips_isa_pkg::OP_SW, '0, rt, window_offset());
            endcase
            n++;
        end
        prog[n]  = `MIPS_HALT_WORD;
        prog_len = n + 1;
    endtask

    // --------------------
    // Reference model
    // --------------------
    // Sequential MIPS semantics, standard encodings
    task automatic run_model();
        mips_isa_pkg::word_t     w;
        mips_isa_pkg::word_t     a;
        mips_isa_pkg::word_t     b;
        mips_isa_pkg::word_t     sext;
        mips_isa_pkg::word_t     zext;
        mips_isa_pkg::word_t     addr;
        mips_isa_pkg::word_t     res;
        mips_isa_pkg::reg_addr_t dst;
        logic                    wr;
        int                      pc;
        for (pc = 0; pc < 32; pc++)
            model_regs[pc] = '0;
        for (pc = 0; pc < DMEM_WORDS; pc++)
            model_mem[pc] = '0;
        for (pc = 0; pc < prog_len - 1; pc++) begin
            w    = prog[pc];
            a    = model_regs[w[25:21]];
            b    = model_regs[w[20:16]];
            sext = {{16{w[15]}}, w[15:0]};
            zext = {16'h0000, w[15:0]};
            addr = a + sext;                        // Load and store address
            res  = '0;
            dst  = w[20:16];                        // rt unless register type
            wr   = 1'b1;
            case (w[31:26])
                6'h00: begin
                    dst = w[15:11];
                    case (w[5:0])
                        6'h20:   res = a + b;
                        6'h22:   res = a - b;
                        6'h24:   res = a & b;
                        6'h25:   res = a | b;
                        6'h26:   res = a ^ b;
                        6'h27:   res = ~(a | b);
                        6'h2A:   res = {31'd0, $signed(a) < $signed(b)};
                        default: wr = 1'b0;
                    endcase
                end
                6'h08: res = a + sext;              // addi, wraps
                6'h0A: res = {31'd0, $signed(a) < $signed(sext)};
                6'h0C: res = a & zext;
                6'h0D: res = a | zext;
                6'h0E: res = a ^ zext;
                6'h0F: res = {w[15:0], 16'h0000};
                6'h23: res = model_mem[addr[`MIPS_NB_DMEM_ADDR + 1 : 2]];
                6'h2B: begin
                    model_mem[addr[`MIPS_NB_DMEM_ADDR + 1 : 2]] = b;
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && (dst != '0))
                model_regs[dst] = res;              // r0 stays zero
        end
    endtask

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_reg(
        input mips_isa_pkg::reg_addr_t idx,
        input mips_isa_pkg::word_t     got,
        input mips_isa_pkg::word_t     exp
    );
        if (got !== exp) begin
            fail_count++;
            $display("** Error at %0t ns: register r%0d reads %h, expected %h",
                     $time, idx, got, exp);
            $display("test failed");
            $fatal(1, "Register mismatch");
        end
    endtask

    task automatic check_mem(
        input logic [`MIPS_NB_DMEM_ADDR - 1 : 0] idx,
        input mips_isa_pkg::word_t               got,
        input mips_isa_pkg::word_t               exp
    );
        if (got !== exp) begin
            fail_count++;
            $display("** Error at %0t ns: data word %0d reads %h, expected %h",
                     $time, idx, got, exp);
            $display("test failed");
            $fatal(1, "Data memory mismatch");
        end
    endtask

    task automatic check_pc(
        input mips_isa_pkg::word_t got,
        input mips_isa_pkg::word_t exp
    );
        if (got !== exp) begin
            fail_count++;
            $display("** Error at %0t ns: PC is %h after halt, expected %h", $time, got, exp);
            $display("test failed");
            $fatal(1, "PC mismatch");
        end
    endtask

    // --------------------
    // Bus tasks
    // --------------------
    task automatic apply_reset();
        @(posedge clock);
        #1;
        rst     = 1'b1;
        run     = 1'b0;
        load_we = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        rst = 1'b0;
    endtask

    // One byte per cycle, little-endian within the word
    task automatic load_program();
        int w;
        int b;
        for (w = 0; w < prog_len; w++) begin
            for (b = 0; b < 4; b++) begin
                @(posedge clock);
                #1;
                load_we   = 1'b1;
                load_byte = prog[w][8 * b +: 8];
            end
        end
        @(posedge clock);
        #1;
        load_we = 1'b0;
    endtask

    task automatic run_test(input int t);
        int i;
        build_program();
        run_model();
        apply_reset();
        load_program();
        run = 1'b1;                                 // Same step as the strobe drop
        do begin
            @(posedge clock);
            #1;
        end while (!program_end);                   // Watchdog covers a hang
        run = 1'b0;
        check_pc(dbg_pc, mips_isa_pkg::word_t'(4 * (prog_len - 1)));
        for (i = 0; i < NUM_POOL; i++) begin
            @(posedge clock);
            #1;
            dbg_reg_addr = mips_isa_pkg::reg_addr_t'(i);
            #4;                                     // Combinational debug read
            check_reg(dbg_reg_addr, dbg_reg, model_regs[i]);
        end
        for (i = 0; i < MEM_WINDOW; i++) begin
            @(posedge clock);
            #1;
            dbg_mem_addr = `MIPS_NB_DMEM_ADDR'(win_base + i);
            #4;
            check_mem(dbg_mem_addr, dbg_mem, model_mem[win_base + i]);
        end
        $display("Test %0d done, %0d words, window at word %0d", t, prog_len, win_base);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin : main_seq
        int t;
        seed         = 68347;
        fail_count   = 0;
        rst          = 1'b1;
        run          = 1'b0;
        load_we      = 1'b0;
        load_byte    = '0;
        dbg_reg_addr = '0;
        dbg_mem_addr = '0;
        for (t = 0; t < NUM_TESTS; t++)
            run_test(t);                            // Each starts with reset and reload
        if (fail_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // Ends the run if a halt never reaches write-back
    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the program never ended", WATCHDOG_NS);
        $display("test failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

//--- mips_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_settings.svh"

module mips_top (
    output mips_isa_pkg::word_t      o_dbg_reg,
    output mips_isa_pkg::word_t      o_dbg_mem,
    output mips_isa_pkg::word_t      o_dbg_pc,
    output logic                     o_is_program_end,
    input  wire mips_isa_pkg::reg_addr_t i_dbg_reg_addr,
    input  wire [`MIPS_NB_DMEM_ADDR - 1 : 0] i_dbg_mem_addr,
    input  wire                [7:0] i_load_byte,
    input  wire                      i_load_we,
    input  wire                      i_run,
    input  wire                      i_rst,
    input  wire                      i_clock
);

    // IF/ID
    mips_isa_pkg::word_t     if_instr;
    // Decode and register file
    mips_isa_pkg::reg_addr_t rs_addr;
    mips_isa_pkg::reg_addr_t rt_addr;
    mips_isa_pkg::word_t     rs_data;
    mips_isa_pkg::word_t     rt_data;
    logic                    stall;
    // ID/EX
    mips_ctrl_pkg::ctrl_t    id_ctrl;
    mips_isa_pkg::word_t     id_op_a;
    mips_isa_pkg::word_t     id_op_b;
    mips_isa_pkg::word_t     id_imm;
    mips_isa_pkg::reg_addr_t id_rs;
    mips_isa_pkg::reg_addr_t id_rt;
    mips_isa_pkg::reg_addr_t id_rd;
    // EX/MEM
    mips_ctrl_pkg::ctrl_t    ex_ctrl;
    mips_isa_pkg::word_t     ex_alu;
    mips_isa_pkg::word_t     ex_store;
    mips_isa_pkg::reg_addr_t ex_rd;
    // MEM/WB
    logic                    wb_en;
    mips_isa_pkg::reg_addr_t wb_rd;
    mips_isa_pkg::word_t     wb_data;

    // --------------------
    // Fetch
    // --------------------
    mips_fetch u_fetch (
        .o_instr     (if_instr   ),
        .o_pc        (o_dbg_pc   ),
        .i_run       (i_run      ),
        .i_stall     (stall      ),
        .i_load_we   (i_load_we  ),
        .i_load_byte (i_load_byte),
        .i_rst       (i_rst      ),
        .i_clock     (i_clock    )
    );

    // --------------------
    // Decode and registers
    // --------------------
    mips_regfile u_regfile (
        .o_rs_data  (rs_data       ),
        .o_rt_data  (rt_data       ),
        .o_dbg_data (o_dbg_reg     ),
        .i_rs_addr  (rs_addr       ),
        .i_rt_addr  (rt_addr       ),
        .i_wr_addr  (wb_rd         ),
        .i_dbg_addr (i_dbg_reg_addr),
        .i_wr_en    (wb_en         ),
        .i_wr_data  (wb_data       ),
        .i_clock    (i_clock       )
    );

    mips_decode u_decode (
        .o_rs_addr     (rs_addr         ),
        .o_rt_addr     (rt_addr         ),
        .o_stall       (stall           ),
        .o_ctrl        (id_ctrl         ),
        .o_op_a        (id_op_a         ),
        .o_op_b        (id_op_b         ),
        .o_imm         (id_imm          ),
        .o_rs          (id_rs           ),
        .o_rt          (id_rt           ),
        .o_rd          (id_rd           ),
        .i_instr       (if_instr        ),
        .i_rs_data     (rs_data         ),
        .i_rt_data     (rt_data         ),
        .i_ex_mem_read (id_ctrl.mem_read),     // Load in ID/EX
        .i_ex_rd       (id_rd           ),
        .i_rst         (i_rst           ),
        .i_clock       (i_clock         )
    );

    // --------------------
    // Execute and memory
    // --------------------
    mips_execute u_execute (
        .o_ctrl    (ex_ctrl ),
        .o_alu     (ex_alu  ),
        .o_store   (ex_store),
        .o_rd      (ex_rd   ),
        .i_ctrl    (id_ctrl ),
        .i_op_a    (id_op_a ),
        .i_op_b    (id_op_b ),
        .i_imm     (id_imm  ),
        .i_rs      (id_rs   ),
        .i_rt      (id_rt   ),
        .i_rd      (id_rd   ),
        .i_wb_en   (wb_en   ),
        .i_wb_rd   (wb_rd   ),
        .i_wb_data (wb_data ),
        .i_rst     (i_rst   ),
        .i_clock   (i_clock )
    );

    mips_memory u_memory (
        .o_wb_en    (wb_en           ),
        .o_wb_rd    (wb_rd           ),
        .o_wb_data  (wb_data         ),
        .o_halt     (o_is_program_end),
        .o_dbg_data (o_dbg_mem       ),
        .i_ctrl     (ex_ctrl         ),
        .i_alu      (ex_alu          ),
        .i_store    (ex_store        ),
        .i_rd       (ex_rd           ),
        .i_dbg_addr (i_dbg_mem_addr  ),
        .i_rst      (i_rst           ),
        .i_clock    (i_clock         )
    );

endmodule

`default_nettype wire

//--- mips_memory.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_settings.svh"

module mips_memory (
    output logic                     o_wb_en,
    output mips_isa_pkg::reg_addr_t  o_wb_rd,
    output mips_isa_pkg::word_t      o_wb_data,
    output logic                     o_halt,            // Sticky until reset
    output mips_isa_pkg::word_t      o_dbg_data,
    input  wire mips_ctrl_pkg::ctrl_t i_ctrl,
    input  wire mips_isa_pkg::word_t i_alu,
    input  wire mips_isa_pkg::word_t i_store,
    input  wire mips_isa_pkg::reg_addr_t i_rd,
    input  wire [`MIPS_NB_DMEM_ADDR - 1 : 0] i_dbg_addr,
    input  wire                      i_rst,
    input  wire                      i_clock
);

    mips_isa_pkg::word_t             dmem [0:(2**`MIPS_NB_DMEM_ADDR) - 1];
    logic [`MIPS_NB_DMEM_ADDR - 1 : 0] addr;
    mips_isa_pkg::word_t             load_data;

    // Word index from byte address, upper bits ignored
    assign addr      = i_alu[`MIPS_NB_DMEM_ADDR + 1 : 2];
    assign load_data = dmem[addr];
    assign o_dbg_data = dmem[i_dbg_addr];               // Host read

    // --------------------
    // Data memory
    // --------------------
    always_ff @(posedge i_clock) begin
        if (i_ctrl.mem_write)
            dmem[addr] <= i_store;
    end

    // --------------------
    // MEM/WB register
    // --------------------
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_wb_en <= 1'b0;
            o_halt  <= 1'b0;
        end else begin
            o_wb_en <= i_ctrl.reg_write;
            if (i_ctrl.halt)
                o_halt <= 1'b1;                         // All older instructions retired
        end
        o_wb_rd   <= i_rd;
        o_wb_data <= i_ctrl.mem_read ? load_data : i_alu;
    end

endmodule

`default_nettype wire

//--- mips_execute.sv
`timescale 1ns/10ps
`default_nettype none

module mips_execute (
    output mips_ctrl_pkg::ctrl_t     o_ctrl,
    output mips_isa_pkg::word_t      o_alu,
    output mips_isa_pkg::word_t      o_store,           // Forwarded rt for stores
    output mips_isa_pkg::reg_addr_t  o_rd,
    input  wire mips_ctrl_pkg::ctrl_t i_ctrl,
    input  wire mips_isa_pkg::word_t i_op_a,
    input  wire mips_isa_pkg::word_t i_op_b,
    input  wire mips_isa_pkg::word_t i_imm,
    input  wire mips_isa_pkg::reg_addr_t i_rs,
    input  wire mips_isa_pkg::reg_addr_t i_rt,
    input  wire mips_isa_pkg::reg_addr_t i_rd,
    input  wire                      i_wb_en,           // MEM/WB write port
    input  wire mips_isa_pkg::reg_addr_t i_wb_rd,
    input  wire mips_isa_pkg::word_t i_wb_data,
    input  wire                      i_rst,
    input  wire                      i_clock
);

    mips_isa_pkg::word_t fwd_a;
    mips_isa_pkg::word_t fwd_b;
    mips_isa_pkg::word_t alu_b;
    mips_isa_pkg::word_t alu_res;

    // EX/MEM first, then MEM/WB, then the value read in decode
    function automatic mips_isa_pkg::word_t forward(
        input mips_isa_pkg::reg_addr_t src,
        input mips_isa_pkg::word_t     id_val
    );
        if (o_ctrl.reg_write && (o_rd != '0) && (o_rd == src))
            return o_alu;
        else if (i_wb_en && (i_wb_rd != '0) && (i_wb_rd == src))
            return i_wb_data;
        else
            return id_val;
    endfunction

    // --------------------
    // Forwarding and ALU
    // --------------------
    always_comb begin
        fwd_a   = forward(i_rs, i_op_a);
        fwd_b   = forward(i_rt, i_op_b);
        alu_b   = i_ctrl.alu_src_imm ? i_imm : fwd_b;
        alu_res = '0;
        case (i_ctrl.alu_op)
            mips_ctrl_pkg::ALU_ADD: alu_res = fwd_a + alu_b;     // Wraps
            mips_ctrl_pkg::ALU_SUB: alu_res = fwd_a - alu_b;
            mips_ctrl_pkg::ALU_AND: alu_res = fwd_a & alu_b;
            mips_ctrl_pkg::ALU_OR:  alu_res = fwd_a | alu_b;
            mips_ctrl_pkg::ALU_XOR: alu_res = fwd_a ^ alu_b;
            mips_ctrl_pkg::ALU_NOR: alu_res = ~(fwd_a | alu_b);
            mips_ctrl_pkg::ALU_SLT: alu_res[0] = $signed(fwd_a) < $signed(alu_b);
            mips_ctrl_pkg::ALU_LUI: alu_res = {alu_b[15:0], 16'h0000};
            default:                alu_res = '0;
        endcase
    end

    // --------------------
    // EX/MEM register
    // --------------------
    always_ff @(posedge i_clock) begin
        if (i_rst)
            o_ctrl <= '0;
        else
            o_ctrl <= i_ctrl;
        o_alu   <= alu_res;
        o_store <= fwd_b;
        o_rd    <= i_rd;
    end

endmodule

`default_nettype wire

//--- mips_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_settings.svh"

module mips_decode (
    output mips_isa_pkg::reg_addr_t  o_rs_addr,
    output mips_isa_pkg::reg_addr_t  o_rt_addr,
    output logic                     o_stall,
    output mips_ctrl_pkg::ctrl_t     o_ctrl,
    output mips_isa_pkg::word_t      o_op_a,
    output mips_isa_pkg::word_t      o_op_b,
    output mips_isa_pkg::word_t      o_imm,
    output mips_isa_pkg::reg_addr_t  o_rs,
    output mips_isa_pkg::reg_addr_t  o_rt,
    output mips_isa_pkg::reg_addr_t  o_rd,
    input  wire mips_isa_pkg::word_t i_instr,
    input  wire mips_isa_pkg::word_t i_rs_data,
    input  wire mips_isa_pkg::word_t i_rt_data,
    input  wire                      i_ex_mem_read,     // Load sits in ID/EX
    input  wire mips_isa_pkg::reg_addr_t i_ex_rd,
    input  wire                      i_rst,
    input  wire                      i_clock
);

    mips_isa_pkg::opcode_t   opcode;
    mips_isa_pkg::funct_t    funct;
    mips_isa_pkg::reg_addr_t dest;
    mips_ctrl_pkg::ctrl_t    ctrl;
    mips_isa_pkg::word_t     imm_ext;
    logic [15:0]             imm16;
    logic                    uses_rt;

    // --------------------
    // Field extraction
    // --------------------
    assign opcode    = mips_isa_pkg::opcode_t'(i_instr[31:26]);
    assign funct     = mips_isa_pkg::funct_t'(i_instr[5:0]);
    assign o_rs_addr = i_instr[25:21];
    assign o_rt_addr = i_instr[20:16];
    assign imm16     = i_instr[15:0];

    // Register type writes rd, immediates and loads write rt
    assign dest = (opcode == mips_isa_pkg::OP_SPECIAL) ? i_instr[15:11] : o_rt_addr;

    // --------------------
    // Control decode
    // --------------------
    always_comb begin
        ctrl = '0;                                  // Unknown codes become bubbles
        if (i_instr == `MIPS_HALT_WORD) begin
            ctrl.halt = 1'b1;
        end else begin
            ctrl.reg_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            case (opcode)
                mips_isa_pkg::OP_SPECIAL: begin
                    ctrl.alu_src_imm = 1'b0;
                    case (funct)
                        mips_isa_pkg::FN_ADD: ctrl.alu_op = mips_ctrl_pkg::ALU_ADD;
                        mips_isa_pkg::FN_SUB: ctrl.alu_op = mips_ctrl_pkg::ALU_SUB;
                        mips_isa_pkg::FN_AND: ctrl.alu_op = mips_ctrl_pkg::ALU_AND;
                        mips_isa_pkg::FN_OR:  ctrl.alu_op = mips_ctrl_pkg::ALU_OR;
                        mips_isa_pkg::FN_XOR: ctrl.alu_op = mips_ctrl_pkg::ALU_XOR;
                        mips_isa_pkg::FN_NOR: ctrl.alu_op = mips_ctrl_pkg::ALU_NOR;
                        mips_isa_pkg::FN_SLT: ctrl.alu_op = mips_ctrl_pkg::ALU_SLT;
                        default:              ctrl.reg_write = 1'b0;    // Also the zero word
                    endcase
                end
                mips_isa_pkg::OP_ADDI: ctrl.alu_op = mips_ctrl_pkg::ALU_ADD;
                mips_isa_pkg::OP_SLTI: ctrl.alu_op = mips_ctrl_pkg::ALU_SLT;
                mips_isa_pkg::OP_ANDI: begin
                    ctrl.imm_zero_ext = 1'b1;
                    ctrl.alu_op       = mips_ctrl_pkg::ALU_AND;
                end
                mips_isa_pkg::OP_ORI: begin
                    ctrl.imm_zero_ext = 1'b1;
                    ctrl.alu_op       = mips_ctrl_pkg::ALU_OR;
                end
                mips_isa_pkg::OP_XORI: begin
                    ctrl.imm_zero_ext = 1'b1;
                    ctrl.alu_op       = mips_ctrl_pkg::ALU_XOR;
                end
                mips_isa_pkg::OP_LUI: begin
                    ctrl.imm_zero_ext = 1'b1;
                    ctrl.alu_op       = mips_ctrl_pkg::ALU_LUI;
                end
                mips_isa_pkg::OP_LW:   ctrl.mem_read = 1'b1;    // Address is rs + imm
                mips_isa_pkg::OP_SW: begin
                    ctrl.reg_write = 1'b0;
                    ctrl.mem_write = 1'b1;
                end
                default: begin
                    ctrl.reg_write   = 1'b0;
                    ctrl.alu_src_imm = 1'b0;
                end
            endcase
        end
    end

    assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

    // --------------------
    // Load-use stall
    // --------------------
    assign uses_rt = !ctrl.alu_src_imm || ctrl.mem_write;     // Rt read by R type and store
    assign o_stall = i_ex_mem_read &&
                     ((i_ex_rd == o_rs_addr) || (uses_rt && (i_ex_rd == o_rt_addr)));

    // --------------------
    // ID/EX register
    // --------------------
    always_ff @(posedge i_clock) begin
        if (i_rst || o_stall)
            o_ctrl <= '0;                           // Bubble
        else
            o_ctrl <= ctrl;
        o_op_a <= i_rs_data;
        o_op_b <= i_rt_data;
        o_imm  <= imm_ext;
        o_rs   <= o_rs_addr;
        o_rt   <= o_rt_addr;
        o_rd   <= dest;
    end

    // Bubble clears the load flag, so a stall lasts one cycle
    a_stall_once : assert property (@(posedge i_clock) disable iff (i_rst)
        o_stall |=> !o_stall);

endmodule

`default_nettype wire

//--- mips_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module mips_regfile (
    output mips_isa_pkg::word_t      o_rs_data,
    output mips_isa_pkg::word_t      o_rt_data,
    output mips_isa_pkg::word_t      o_dbg_data,
    input  wire mips_isa_pkg::reg_addr_t i_rs_addr,
    input  wire mips_isa_pkg::reg_addr_t i_rt_addr,
    input  wire mips_isa_pkg::reg_addr_t i_wr_addr,
    input  wire mips_isa_pkg::reg_addr_t i_dbg_addr,
    input  wire                      i_wr_en,
    input  wire mips_isa_pkg::word_t i_wr_data,
    input  wire                      i_clock
);

    mips_isa_pkg::word_t regs [0:31];   // Entry 0 is never written

    // Read with register 0 forced to zero and optional same-cycle bypass
    function automatic mips_isa_pkg::word_t read_port(
        input mips_isa_pkg::reg_addr_t addr,
        input logic                    bypass
    );
        if (addr == '0)
            return '0;
        else if (bypass && i_wr_en && (i_wr_addr == addr))
            return i_wr_data;                   // Write-first
        else
            return regs[addr];
    endfunction

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge i_clock) begin
        if (i_wr_en && (i_wr_addr != '0))
            regs[i_wr_addr] <= i_wr_data;
    end

    // --------------------
    // Read ports
    // --------------------
    always_comb begin
        o_rs_data  = read_port(i_rs_addr, 1'b1);
        o_rt_data  = read_port(i_rt_addr, 1'b1);
        o_dbg_data = read_port(i_dbg_addr, 1'b0);   // Host view without bypass
    end

    // A write aimed at register 0 is never bypassed onto a read of it
    a_reg0_zero : assert property (@(posedge i_clock)
        (i_wr_en && (i_wr_addr == '0)) |->
            (((i_rs_addr != '0) || (o_rs_data == '0)) &&
             ((i_rt_addr != '0) || (o_rt_data == '0))));

endmodule

`default_nettype wire

//--- mips_fetch.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_settings.svh"

module mips_fetch (
    output mips_isa_pkg::word_t      o_instr,
    output mips_isa_pkg::word_t      o_pc,
    input  wire                      i_run,
    input  wire                      i_stall,
    input  wire                      i_load_we,
    input  wire                [7:0] i_load_byte,
    input  wire                      i_rst,
    input  wire                      i_clock
);

    logic [7:0]                        imem [0:(2**`MIPS_NB_IMEM_ADDR) - 1];
    logic [`MIPS_NB_IMEM_ADDR - 1 : 0] load_ptr;
    logic [`MIPS_NB_IMEM_ADDR - 1 : 0] fetch_addr;
    mips_isa_pkg::word_t               fetch_word;
    logic                              stopped;         // Set once the halt is fetched

    assign fetch_addr = o_pc[`MIPS_NB_IMEM_ADDR - 1 : 0];
    assign fetch_word = {imem[fetch_addr + 3], imem[fetch_addr + 2],
                         imem[fetch_addr + 1], imem[fetch_addr]};

    // --------------------
    // Program load with one byte per cycle
    // --------------------
    always_ff @(posedge i_clock) begin
        if (i_rst)
            load_ptr <= '0;
        else if (i_load_we) begin
            imem[load_ptr] <= i_load_byte;
            load_ptr       <= load_ptr + 1'b1;
        end
    end

    // --------------------
    // PC and IF/ID register
    // --------------------
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_pc    <= '0;
            o_instr <= '0;
            stopped <= 1'b0;
        end else if (!i_run) begin
            o_instr <= '0;                              // Bubble
        end else if (!i_stall) begin
            if (stopped) begin
                o_instr <= '0;                          // Only bubbles after the halt
            end else begin
                o_instr <= fetch_word;
                if (fetch_word == `MIPS_HALT_WORD)
                    stopped <= 1'b1;                    // Halt holds the PC
                else
                    o_pc <= o_pc + 32'd4;
            end
        end
    end

    // Host loads only while the core is idle
    a_no_load_in_run : assert property (@(posedge i_clock) disable iff (i_rst)
        !(i_run && i_load_we));

endmodule

`default_nettype wire

//--- mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

    // --------------------
    // ALU operations
    // --------------------
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,                // Signed less than, result 0 or 1
        ALU_LUI                 // Immediate into upper half
    } alu_op_t;

    // --------------------
    // Decoded control bundle
    // --------------------
    // All zero is a bubble
    typedef struct packed {
        logic    reg_write;     // Writes rd or rt
        logic    mem_read;      // Load
        logic    mem_write;     // Store
        logic    alu_src_imm;   // Operand b from immediate
        logic    imm_zero_ext;  // Logical immediates
        logic    halt;          // End of program
        alu_op_t alu_op;
    } ctrl_t;

endpackage

`default_nettype wire

//--- mips_isa_pkg.sv
`default_nettype none

`include "mips_settings.svh"

package mips_isa_pkg;

    // --------------------
    // Basic word types
    // --------------------
    typedef logic [`MIPS_NB_DATA     - 1 : 0] word_t;      // Data or instruction word
    typedef logic [`MIPS_NB_REG_ADDR - 1 : 0] reg_addr_t;  // Register number

    // Primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,     // Register type, see funct
        OP_ADDI    = 6'h08,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,     // Word load only
        OP_SW      = 6'h2B      // Word store only
    } opcode_t;

    // Function codes of OP_SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,         // Wraps, no trap
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_NOR = 6'h27,
        FN_SLT = 6'h2A          // Signed compare
    } funct_t;

endpackage

`default_nettype wire

//--- mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// --------------------
// Datapath widths
// --------------------
`define MIPS_NB_DATA        32          // Data and instruction word
`define MIPS_NB_REG_ADDR    5           // 32 registers

// --------------------
// Memory depths
// --------------------
// Instruction memory is byte addressed, 512 bytes
`define MIPS_NB_IMEM_ADDR   9
// Data memory is word addressed, 128 words
`define MIPS_NB_DMEM_ADDR   7

// --------------------
// Program end marker
// --------------------
`define MIPS_HALT_WORD      32'hFFFF_FFFF

`endif
